//--- hdl/rumble_pkg.sv
// Shared constants for the game core
// Memory map of both SDRAM banks, ROM client widths and video frame sizes
package rumble_pkg;

    // Word address width of one SDRAM bank
    localparam int SDRAM_AW = 22;

    // Main and sound addresses count bytes
    localparam int MAINW = 18;
    localparam int SNDW  = 15;
    // Char and obj addresses count words
    localparam int CHARW = 13;
    localparam int OBJW  = 17;

    // Word base of each client inside its bank
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = 22'h02_0000;
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET  = 22'h00_2000;

    // Download byte map
    localparam logic [24:0] BA1_START  = 25'h004_8000;
    localparam logic [24:0] PROM_START = 25'h008_C000;

    // Frame geometry in pixels and lines
    localparam int HTOTAL = 384;
    localparam int HVIS   = 256;
    localparam int VTOTAL = 262;
    localparam int VVIS   = 224;

    localparam int HS_START = 296;
    localparam int HS_LEN   = 32;
    localparam int VS_START = 232;
    localparam int VS_LEN   = 8;

endpackage

//--- hdl/rumble_vtiming.sv
// Video timing generator
// Pixel clock enables, beam counters, blanking and sync pulses
module rumble_vtiming import rumble_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       pxl2_cen,
    output logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       LHBL,
    output logic       LVBL,
    output logic       HS,
    output logic       VS
);

    logic [2:0] cen_cnt;
    logic       h_last;
    logic       v_last;

    assign h_last = hdump == 9'(HTOTAL - 1);
    assign v_last = vdump == 9'(VTOTAL - 1);

    // Divide clk by 4 and by 8
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_cnt  <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cen_cnt  <= cen_cnt + 3'd1;
            pxl2_cen <= cen_cnt[1:0] == 2'b11;
            pxl_cen  <= cen_cnt == 3'b111;
        end
    end

    // Beam position
    always_ff @(posedge clk) begin
        if (reset) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= 9'd0;
                if (v_last) begin
                    vdump <= 9'd0;
                end else begin
                    vdump <= vdump + 9'd1;
                end
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    // Blanking and sync lag the counters by one pixel
    always_ff @(posedge clk) begin
        if (reset) begin
            LHBL <= 1'b1;
            LVBL <= 1'b1;
            HS   <= 1'b0;
            VS   <= 1'b0;
        end else if (pxl_cen) begin
            LHBL <= hdump < 9'(HVIS);
            LVBL <= vdump < 9'(VVIS);
            HS   <= hdump >= 9'(HS_START) && hdump < 9'(HS_START + HS_LEN);
            VS   <= vdump >= 9'(VS_START) && vdump < 9'(VS_START + VS_LEN);
        end
    end

endmodule

//--- hdl/rumble_rom_slot.sv
// ROM client slot
// Keeps the last fetched word and requests a bank read on a miss
module rumble_rom_slot import rumble_pkg::*; #(
    parameter int                   AW     = 18,
    parameter int                   DW     = 8,
    parameter logic [SDRAM_AW-1:0]  OFFSET = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cs,
    input  logic [AW-1:0]       addr,
    input  logic                grant_rdy,
    input  logic [15:0]         grant_data,
    output logic                ok,
    output logic [DW-1:0]       data,
    output logic                req,
    output logic [SDRAM_AW-1:0] req_addr
);

    // Byte clients drop bit 0 to get the word address
    localparam int WAW = (DW == 8) ? AW - 1 : AW;

    logic [WAW-1:0] waddr;
    logic [WAW-1:0] fetch_addr;
    logic [WAW-1:0] cache_addr;
    logic [15:0]    cache_word;
    logic           cache_valid;
    logic           hit;
    logic           miss;

    assign waddr    = addr[AW-1 -: WAW];
    assign hit      = cache_valid && cache_addr == waddr;
    assign miss     = cs && !hit && !req;
    assign ok       = cs && hit;
    assign req_addr = OFFSET + SDRAM_AW'(fetch_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            req         <= 1'b0;
            cache_valid <= 1'b0;
        end else if (grant_rdy) begin
            req         <= 1'b0;
            cache_valid <= 1'b1;
        end else if (miss) begin
            req <= 1'b1;
        end
    end

    // Address is frozen while the request is pending
    always_ff @(posedge clk) begin
        if (miss) begin
            fetch_addr <= waddr;
        end
        if (grant_rdy) begin
            cache_word <= grant_data;
            cache_addr <= fetch_addr;
        end
    end

    generate
        if (DW == 8) begin : g_byte
            // Even address reads the low byte
            assign data = addr[0] ? cache_word[15:8] : cache_word[7:0];
        end else begin : g_word
            assign data = cache_word;
        end
    endgenerate

endmodule

//--- hdl/rumble_bank_arb.sv
// Two-client SDRAM bank arbiter
// Issues one read at a time and returns the word to the client that won
module rumble_bank_arb import rumble_pkg::*; #(
    parameter bit ROUND_ROBIN = 1'b0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                halt,
    input  logic                prio_b,
    input  logic                a_req,
    input  logic [SDRAM_AW-1:0] a_addr,
    input  logic                b_req,
    input  logic [SDRAM_AW-1:0] b_addr,
    input  logic                ba_ack,
    input  logic                ba_rdy,
    input  logic [15:0]         data_read,
    output logic                a_rdy,
    output logic                b_rdy,
    output logic [15:0]         grant_data,
    output logic                ba_rd,
    output logic [SDRAM_AW-1:0] ba_addr
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;
    localparam logic [1:0] ST_RDY  = 2'd2;

    logic [1:0] state;
    logic       owner_b;
    logic       a_go;
    logic       b_go;
    logic       pick_b;
    logic       issue;

    // A client being answered still shows req for one more cycle
    assign a_go  = a_req && !a_rdy;
    assign b_go  = b_req && !b_rdy;
    assign issue = state == ST_IDLE && !halt && (a_go || b_go);

    always_comb begin
        if (a_go && b_go) begin
            pick_b = ROUND_ROBIN ? !owner_b : prio_b;
        end else begin
            pick_b = b_go;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            ba_rd   <= 1'b0;
            a_rdy   <= 1'b0;
            b_rdy   <= 1'b0;
            owner_b <= 1'b0;
        end else begin
            a_rdy <= 1'b0;
            b_rdy <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (issue) begin
                        ba_rd   <= 1'b1;
                        owner_b <= pick_b;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= ST_RDY;
                    end
                end
                ST_RDY: begin
                    if (ba_rdy) begin
                        a_rdy <= !owner_b;
                        b_rdy <= owner_b;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ba_addr <= pick_b ? b_addr : a_addr;
        end
        if (state == ST_RDY && ba_rdy) begin
            grant_data <= data_read;
        end
    end

endmodule

//--- hdl/rumble_dwnld.sv
// ROM download unit
// Packs host bytes into 16-bit SDRAM writes and forwards priority PROM bytes
module rumble_dwnld import rumble_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    input  logic                prog_rdy,
    output logic                dwnld_busy,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [15:0]         prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_ba,
    output logic                prog_we,
    output logic                prom_prior_we
);

    logic        wr_en;
    logic        is_prom;
    logic        is_ba1;
    logic [24:0] region_base;
    logic [24:0] rel_addr;
    logic [7:0]  byte_lo;

    assign wr_en    = downloading && ioctl_wr;
    assign is_prom  = ioctl_addr >= PROM_START;
    assign is_ba1   = ioctl_addr >= BA1_START;
    // Both bytes always written
    assign prog_mask = 2'b00;

    always_comb begin
        if (is_prom) begin
            region_base = PROM_START;
        end else if (is_ba1) begin
            region_base = BA1_START;
        end else begin
            region_base = 25'd0;
        end
    end

    assign rel_addr = ioctl_addr - region_base;

    always_ff @(posedge clk) begin
        if (reset) begin
            dwnld_busy    <= 1'b0;
            prog_we       <= 1'b0;
            prom_prior_we <= 1'b0;
        end else begin
            dwnld_busy    <= downloading;
            prom_prior_we <= wr_en && is_prom;
            if (wr_en && !is_prom && ioctl_addr[0]) begin
                prog_we <= 1'b1;
            end else if (prog_rdy) begin
                prog_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (is_prom) begin
                // PROM holds 4-bit entries
                prog_addr <= SDRAM_AW'(rel_addr);
                prog_data <= {12'd0, ioctl_dout[3:0]};
            end else if (!ioctl_addr[0]) begin
                byte_lo <= ioctl_dout;
            end else begin
                prog_addr <= rel_addr[SDRAM_AW:1];
                prog_data <= {ioctl_dout, byte_lo};
                prog_ba   <= {1'b0, is_ba1};
            end
        end
    end

endmodule

//--- hdl/rumble_game.sv
// Game core memory and timing subsystem
// Video timing, ROM slots on two SDRAM banks and the ROM download path
module rumble_game import rumble_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    // Video
    output logic                pxl2_cen,
    output logic                pxl_cen,
    output logic                LHBL,
    output logic                LVBL,
    output logic                HS,
    output logic                VS,
    output logic [8:0]          vdump,
    // ROM clients
    input  logic                main_cs,
    input  logic [MAINW-1:0]    main_addr,
    output logic [7:0]          main_data,
    output logic                main_ok,
    input  logic                snd_cs,
    input  logic [SNDW-1:0]     snd_addr,
    output logic [7:0]          snd_data,
    output logic                snd_ok,
    input  logic                char_cs,
    input  logic [CHARW-1:0]    char_addr,
    output logic [15:0]         char_data,
    output logic                char_ok,
    input  logic                obj_cs,
    input  logic [OBJW-1:0]     obj_addr,
    output logic [15:0]         obj_data,
    output logic                obj_ok,
    // SDRAM banks
    output logic [SDRAM_AW-1:0] ba0_addr,
    output logic [SDRAM_AW-1:0] ba1_addr,
    output logic [1:0]          ba_rd,
    input  logic [1:0]          ba_ack,
    input  logic [1:0]          ba_rdy,
    input  logic [15:0]         data_read,
    // Download
    input  logic                downloading,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    input  logic                prog_rdy,
    output logic                dwnld_busy,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [15:0]         prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_ba,
    output logic                prog_we,
    output logic                prom_prior_we
);

    logic                main_req;
    logic                snd_req;
    logic                char_req;
    logic                obj_req;
    logic [SDRAM_AW-1:0] main_req_addr;
    logic [SDRAM_AW-1:0] snd_req_addr;
    logic [SDRAM_AW-1:0] char_req_addr;
    logic [SDRAM_AW-1:0] obj_req_addr;
    logic                main_rdy;
    logic                snd_rdy;
    logic                char_rdy;
    logic                obj_rdy;
    logic [15:0]         ba0_data;
    logic [15:0]         ba1_data;

    rumble_vtiming u_vtiming (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    (          ),
        .vdump    ( vdump    ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .HS       ( HS       ),
        .VS       ( VS       )
    );

    // Bank 0 clients
    rumble_rom_slot #(.AW(MAINW), .DW(8), .OFFSET(MAIN_OFFSET)) u_main_slot (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cs         ( main_cs       ),
        .addr       ( main_addr     ),
        .grant_rdy  ( main_rdy      ),
        .grant_data ( ba0_data      ),
        .ok         ( main_ok       ),
        .data       ( main_data     ),
        .req        ( main_req      ),
        .req_addr   ( main_req_addr )
    );

    rumble_rom_slot #(.AW(SNDW), .DW(8), .OFFSET(SND_OFFSET)) u_snd_slot (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cs         ( snd_cs        ),
        .addr       ( snd_addr      ),
        .grant_rdy  ( snd_rdy       ),
        .grant_data ( ba0_data      ),
        .ok         ( snd_ok        ),
        .data       ( snd_data      ),
        .req        ( snd_req       ),
        .req_addr   ( snd_req_addr  )
    );

    // Bank 1 clients
    rumble_rom_slot #(.AW(CHARW), .DW(16), .OFFSET(CHAR_OFFSET)) u_char_slot (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cs         ( char_cs       ),
        .addr       ( char_addr     ),
        .grant_rdy  ( char_rdy      ),
        .grant_data ( ba1_data      ),
        .ok         ( char_ok       ),
        .data       ( char_data     ),
        .req        ( char_req      ),
        .req_addr   ( char_req_addr )
    );

    rumble_rom_slot #(.AW(OBJW), .DW(16), .OFFSET(OBJ_OFFSET)) u_obj_slot (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cs         ( obj_cs        ),
        .addr       ( obj_addr      ),
        .grant_rdy  ( obj_rdy       ),
        .grant_data ( ba1_data      ),
        .ok         ( obj_ok        ),
        .data       ( obj_data      ),
        .req        ( obj_req       ),
        .req_addr   ( obj_req_addr  )
    );

    // CPUs take turns on bank 0
    rumble_bank_arb #(.ROUND_ROBIN(1'b1)) u_arb0 (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .halt       ( dwnld_busy    ),
        .prio_b     ( 1'b0          ),
        .a_req      ( main_req      ),
        .a_addr     ( main_req_addr ),
        .b_req      ( snd_req       ),
        .b_addr     ( snd_req_addr  ),
        .ba_ack     ( ba_ack[0]     ),
        .ba_rdy     ( ba_rdy[0]     ),
        .data_read  ( data_read     ),
        .a_rdy      ( main_rdy      ),
        .b_rdy      ( snd_rdy       ),
        .grant_data ( ba0_data      ),
        .ba_rd      ( ba_rd[0]      ),
        .ba_addr    ( ba0_addr      )
    );

    // Sprites go first during vertical blank
    rumble_bank_arb #(.ROUND_ROBIN(1'b0)) u_arb1 (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .halt       ( dwnld_busy    ),
        .prio_b     ( ~LVBL         ),
        .a_req      ( char_req      ),
        .a_addr     ( char_req_addr ),
        .b_req      ( obj_req       ),
        .b_addr     ( obj_req_addr  ),
        .ba_ack     ( ba_ack[1]     ),
        .ba_rdy     ( ba_rdy[1]     ),
        .data_read  ( data_read     ),
        .a_rdy      ( char_rdy      ),
        .b_rdy      ( obj_rdy       ),
        .grant_data ( ba1_data      ),
        .ba_rd      ( ba_rd[1]      ),
        .ba_addr    ( ba1_addr      )
    );

    rumble_dwnld u_dwnld (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .downloading   ( downloading   ),
        .ioctl_addr    ( ioctl_addr    ),
        .ioctl_dout    ( ioctl_dout    ),
        .ioctl_wr      ( ioctl_wr      ),
        .prog_rdy      ( prog_rdy      ),
        .dwnld_busy    ( dwnld_busy    ),
        .prog_addr     ( prog_addr     ),
        .prog_data     ( prog_data     ),
        .prog_mask     ( prog_mask     ),
        .prog_ba       ( prog_ba       ),
        .prog_we       ( prog_we       ),
        .prom_prior_we ( prom_prior_we )
    );

endmodule

//--- verif/sdram_model.sv
// Behavioural two-bank SDRAM
// Random ack and ready latency, one read in flight, plus a programming port
module sdram_model (
    input  logic        clk,
    input  logic [1:0]  ba_rd,
    input  logic [21:0] ba0_addr,
    input  logic [21:0] ba1_addr,
    output logic [1:0]  ba_ack,
    output logic [1:0]  ba_rdy,
    output logic [15:0] data_read,
    input  logic        prog_we,
    input  logic [21:0] prog_addr,
    input  logic [15:0] prog_data,
    input  logic [1:0]  prog_ba,
    output logic        prog_rdy
);

    logic [15:0] mem0 [int];
    logic [15:0] mem1 [int];
    int          bank;
    int          last_bank;
    int          rd_addr;

    // Unwritten words read back as a pattern of the whole address
    function automatic logic [15:0] read_word(input int b, input int a);
        if (b == 0 && mem0.exists(a)) begin
            return mem0[a];
        end else if (b == 1 && mem1.exists(a)) begin
            return mem1[a];
        end
        return 16'(a ^ (a >> 7) ^ (b << 15));
    endfunction

    initial begin
        ba_ack    = 2'b00;
        ba_rdy    = 2'b00;
        data_read = 16'd0;
        prog_rdy  = 1'b0;
        last_bank = 1;
    end

    // Read port, one bank at a time since data_read is shared
    initial begin
        forever begin
            @(negedge clk);
            if (ba_rd != 2'b00) begin
                if (ba_rd == 2'b11) begin
                    bank = 1 - last_bank;
                end else begin
                    bank = ba_rd[1] ? 1 : 0;
                end
                last_bank = bank;
                rd_addr = (bank == 0) ? int'(ba0_addr) : int'(ba1_addr);
                repeat ($urandom_range(0, 3)) @(negedge clk);
                ba_ack[bank] = 1'b1;
                @(negedge clk);
                ba_ack[bank] = 1'b0;
                repeat ($urandom_range(1, 4)) @(negedge clk);
                data_read    = read_word(bank, rd_addr);
                ba_rdy[bank] = 1'b1;
                @(negedge clk);
                ba_rdy[bank] = 1'b0;
            end
        end
    end

    // Programming port
    initial begin
        forever begin
            @(negedge clk);
            if (prog_we && !prog_rdy) begin
                repeat ($urandom_range(0, 2)) @(negedge clk);
                if (prog_ba == 2'd0) begin
                    mem0[int'(prog_addr)] = prog_data;
                end else begin
                    mem1[int'(prog_addr)] = prog_data;
                end
                prog_rdy = 1'b1;
                @(negedge clk);
                prog_rdy = 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_rumble.sv
// Testbench for the game core memory and timing subsystem
// Downloads an image, reads it back through all ROM clients, checks video timing
module tb_rumble import rumble_pkg::*; ();

    localparam int FRAME_CLKS = HTOTAL * VTOTAL * 8 + 100;

    logic              clk;
    logic              reset;
    logic              pxl2_cen, pxl_cen, LHBL, LVBL, HS, VS;
    logic [8:0]        vdump;
    logic              main_cs, snd_cs, char_cs, obj_cs;
    logic [MAINW-1:0]  main_addr;
    logic [SNDW-1:0]   snd_addr;
    logic [CHARW-1:0]  char_addr;
    logic [OBJW-1:0]   obj_addr;
    logic [7:0]        main_data, snd_data;
    logic [15:0]       char_data, obj_data;
    logic              main_ok, snd_ok, char_ok, obj_ok;
    logic [21:0]       ba0_addr, ba1_addr;
    logic [1:0]        ba_rd, ba_ack, ba_rdy;
    logic [15:0]       data_read;
    logic              downloading, ioctl_wr, prog_rdy;
    logic [24:0]       ioctl_addr;
    logic [7:0]        ioctl_dout;
    logic              dwnld_busy, prog_we, prom_prior_we;
    logic [21:0]       prog_addr;
    logic [15:0]       prog_data;
    logic [1:0]        prog_mask, prog_ba;

    // Reference copy of the downloaded bytes
    logic [7:0]        ref_img [int];
    logic              dl_check;
    logic [1:0]        rd_prev;
    int                rd_rises [2];
    int                last_addr [4];
    int                n, cnt, cnt2, a0, a1;
    bit                done0, done1;
    logic [8:0]        v_prev;
    logic              prev;

    rumble_game DUT (.*);

    sdram_model u_sdram (
        .clk(clk), .ba_rd(ba_rd), .ba0_addr(ba0_addr), .ba1_addr(ba1_addr),
        .ba_ack(ba_ack), .ba_rdy(ba_rdy), .data_read(data_read),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_ba(prog_ba), .prog_rdy(prog_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic stop_on(input bit bad, input string what);
        assert (!bad) else begin
            $display("Error at %0t: %s", $time, what);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Count read starts per bank
    always @(negedge clk) begin
        rd_prev <= ba_rd;
        if (ba_rd[0] && !rd_prev[0]) rd_rises[0] <= rd_rises[0] + 1;
        if (ba_rd[1] && !rd_prev[1]) rd_rises[1] <= rd_rises[1] + 1;
        if (dl_check) begin
            check_value("ba_rd", 32'(ba_rd), 32'd0);
            check_value("dwnld_busy", 32'(dwnld_busy), 32'd1);
        end
    end

    task automatic send_byte(input int a, input logic [7:0] d);
        int  t;
        int  rel;
        @(negedge clk);
        ioctl_addr = 25'(a);
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
        ref_img[a] = d;
        if (a >= int'(PROM_START)) begin
            t = 0;
            while (!prom_prior_we) begin
                stop_on(prog_we, "prog_we raised for a PROM byte");
                @(negedge clk);
                t++;
                stop_on(t > 4, "prom_prior_we never pulsed");
            end
            check_value("prog_addr", 32'(prog_addr[7:0]), 32'((a - int'(PROM_START)) & 255));
            check_value("prog_data", 32'(prog_data[3:0]), 32'(d[3:0]));
            check_value("prog_we", 32'(prog_we), 32'd0);
            // PROM strobe lasts a single cycle
            @(negedge clk);
            check_value("prom_prior_we", 32'(prom_prior_we), 32'd0);
            check_value("prog_we", 32'(prog_we), 32'd0);
        end else if (a[0]) begin
            rel = (a >= int'(BA1_START)) ? a - int'(BA1_START) : a;
            t = 0;
            while (!prog_we) begin
                @(negedge clk);
                t++;
                stop_on(t > 4, "prog_we never rose");
            end
            check_value("prog_addr", 32'(prog_addr), 32'(rel >> 1));
            check_value("prog_data", 32'(prog_data), {16'd0, d, ref_img[a - 1]});
            check_value("prog_mask", 32'(prog_mask), 32'd0);
            check_value("prog_ba", 32'(prog_ba), (a >= int'(BA1_START)) ? 32'd1 : 32'd0);
            t = 0;
            while (prog_we) begin
                @(negedge clk);
                t++;
                stop_on(t > 20, "prog_we stuck high");
            end
        end
    endtask

    task automatic set_client(input int c, input logic cs, input int a);
        case (c)
            0: begin
                main_cs   = cs;
                main_addr = MAINW'(a);
            end
            1: begin
                snd_cs   = cs;
                snd_addr = SNDW'(a);
            end
            2: begin
                char_cs   = cs;
                char_addr = CHARW'(a);
            end
            default: begin
                obj_cs   = cs;
                obj_addr = OBJW'(a);
            end
        endcase
        last_addr[c] = a;
    endtask

    function automatic logic client_ok(input int c);
        return (c == 0) ? main_ok : (c == 1) ? snd_ok : (c == 2) ? char_ok : obj_ok;
    endfunction

    function automatic logic [15:0] client_data(input int c);
        return (c == 0) ? {8'd0, main_data} : (c == 1) ? {8'd0, snd_data} :
               (c == 2) ? char_data : obj_data;
    endfunction

    // Expected value from the image bytes and the memory map
    function automatic logic [15:0] expected_data(input int c, input int a);
        int b;
        if (c == 0) return {8'd0, ref_img[2 * int'(MAIN_OFFSET) + a]};
        if (c == 1) return {8'd0, ref_img[2 * int'(SND_OFFSET) + a]};
        b = int'(BA1_START) + 2 * ((c == 2) ? int'(CHAR_OFFSET) : int'(OBJ_OFFSET)) + 2 * a;
        return {ref_img[b + 1], ref_img[b]};
    endfunction

    task automatic read_and_hold(input int c, input int a);
        int t;
        int rises;
        @(negedge clk);
        set_client(c, 1'b1, a);
        t = 0;
        do begin
            @(negedge clk);
            t++;
            stop_on(t > 300, "ok never rose on a read");
        end while (!client_ok(c));
        check_value("data", 32'(client_data(c)), 32'(expected_data(c, a)));
        rises = rd_rises[c / 2];
        repeat (6) begin
            @(negedge clk);
            check_value("ok", 32'(client_ok(c)), 32'd1);
            check_value("ba_rd rises", rd_rises[c / 2], rises);
        end
        set_client(c, 1'b0, a);
    endtask

    initial begin
        void'($urandom(69366));
        reset = 1'b1;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        dl_check = 1'b0;
        rd_rises[0] = 0;
        rd_rises[1] = 0;
        for (int c = 0; c < 4; c++) set_client(c, 1'b0, 0);
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // Download with main already asking, so the halt is exercised
        downloading = 1'b1;
        set_client(0, 1'b1, 0);
        repeat (2) @(negedge clk);
        dl_check = 1'b1;
        for (int i = 0; i < 64; i++) send_byte(2 * int'(MAIN_OFFSET) + i, 8'($urandom));
        for (int i = 0; i < 64; i++) send_byte(2 * int'(SND_OFFSET) + i, 8'($urandom));
        for (int i = 0; i < 64; i++) send_byte(int'(BA1_START) + 2 * int'(CHAR_OFFSET) + i,
                                               8'($urandom));
        for (int i = 0; i < 64; i++) send_byte(int'(BA1_START) + 2 * int'(OBJ_OFFSET) + i,
                                               8'($urandom));
        for (int i = 0; i < 8; i++) send_byte(int'(PROM_START) + i, 8'($urandom));
        dl_check = 1'b0;
        downloading = 1'b0;
        n = 0;
        while (!main_ok) begin
            @(negedge clk);
            n++;
            stop_on(n > 300, "main read after download never completed");
        end
        check_value("main_data", 32'(main_data), 32'(expected_data(0, 0)));
        set_client(0, 1'b0, 0);

        // Random reads with a hit check on each
        for (int r = 0; r < 10; r++) begin
            read_and_hold(0, $urandom_range(0, 63));
            read_and_hold(1, $urandom_range(0, 63));
            read_and_hold(2, $urandom_range(0, 31));
            read_and_hold(3, $urandom_range(0, 31));
        end

        // Bank 0 clients at once, with new words to force misses
        @(negedge clk);
        a0 = (last_addr[0] + 2) % 64;
        a1 = (last_addr[1] + 2) % 64;
        set_client(0, 1'b1, a0);
        set_client(1, 1'b1, a1);
        done0 = 0;
        done1 = 0;
        n = 0;
        while (!(done0 && done1)) begin
            @(negedge clk);
            n++;
            stop_on(n > 400, "main and snd requests not both served");
            if (main_ok && !done0) begin
                check_value("main_data", 32'(main_data), 32'(expected_data(0, a0)));
                done0 = 1;
            end
            if (snd_ok && !done1) begin
                check_value("snd_data", 32'(snd_data), 32'(expected_data(1, a1)));
                done1 = 1;
            end
        end
        set_client(0, 1'b0, a0);
        set_client(1, 1'b0, a1);

        // Bank 1 during vertical blank
        n = 0;
        while (LVBL) begin
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "LVBL never went low");
        end
        a0 = (last_addr[2] + 1) % 32;
        a1 = (last_addr[3] + 1) % 32;
        set_client(2, 1'b1, a0);
        set_client(3, 1'b1, a1);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            stop_on(n > 300, "no bank 1 request served");
        end while (!char_ok && !obj_ok);
        check_value("obj_ok", 32'(obj_ok), 32'd1);
        check_value("char_ok", 32'(char_ok), 32'd0);
        check_value("obj_data", 32'(obj_data), 32'(expected_data(3, a1)));
        n = 0;
        while (!char_ok) begin
            @(negedge clk);
            n++;
            stop_on(n > 300, "char request never served");
        end
        check_value("char_data", 32'(char_data), 32'(expected_data(2, a0)));
        set_client(2, 1'b0, a0);
        set_client(3, 1'b0, a1);

        // Pixels per line between HS rises
        prev = HS;
        n = 0;
        do begin
            prev = HS;
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "HS never rose");
        end while (!(HS && !prev));
        cnt = 0;
        cnt2 = 0;
        n = 0;
        do begin
            prev = HS;
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "second HS rise missing");
            if (pxl_cen) cnt++;
            if (pxl2_cen) cnt2++;
        end while (!(HS && !prev));
        check_value("pxl_cen per line", cnt, HTOTAL);
        check_value("pxl2_cen per line", cnt2, 2 * HTOTAL);

        // Horizontal blank width, starting from the active part of a line
        n = 0;
        while (!LHBL) begin
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "LHBL stuck low");
        end
        while (LHBL) begin
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "LHBL never went low");
        end
        cnt = 0;
        while (!LHBL) begin
            if (pxl_cen) cnt++;
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "LHBL stuck low");
        end
        check_value("LHBL low pixels", cnt, HTOTAL - HVIS);

        // Vertical blank height in lines
        n = 0;
        while (!LVBL) begin
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "LVBL stuck low");
        end
        while (LVBL) begin
            @(negedge clk);
            n++;
            stop_on(n > 2 * FRAME_CLKS, "LVBL never fell");
        end
        cnt = 0;
        v_prev = vdump;
        while (!LVBL) begin
            if (vdump != v_prev) cnt++;
            v_prev = vdump;
            @(negedge clk);
            n++;
            stop_on(n > 3 * FRAME_CLKS, "LVBL never rose");
        end
        check_value("LVBL low lines", cnt, VTOTAL - VVIS);

        // Vertical sync height in lines
        n = 0;
        while (!VS) begin
            @(negedge clk);
            n++;
            stop_on(n > FRAME_CLKS, "VS never rose");
        end
        cnt = 0;
        v_prev = vdump;
        while (VS) begin
            if (vdump != v_prev) cnt++;
            v_prev = vdump;
            @(negedge clk);
            n++;
            stop_on(n > 2 * FRAME_CLKS, "VS stuck high");
        end
        check_value("VS high lines", cnt, VS_LEN);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sim.f
hdl/rumble_pkg.sv
hdl/rumble_vtiming.sv
hdl/rumble_rom_slot.sv
hdl/rumble_bank_arb.sv
hdl/rumble_dwnld.sv
hdl/rumble_game.sv
verif/sdram_model.sv
verif/tb_rumble.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_rumble -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    exit 1
fi
exit 0
